// ==== pipe_pkg.sv ====
package pipe_pkg;

  // datapath and register-file widths
  localparam int data_w  = 32;
  localparam int rf_aw   = 5;

  // exception bus
  localparam int ebus_w    = 16;
  localparam int ebus_adef = 0;
  localparam int ebus_ale  = 1;
  localparam int ebus_sys  = 2;

  // one-hot load kind, same bit order as the decoder: {w, b, bu, h, hu}
  typedef logic [4:0] ld_op_t;

  localparam ld_op_t ld_none = 5'b00000;
  localparam ld_op_t ld_w    = 5'b10000;
  localparam ld_op_t ld_b    = 5'b01000;
  localparam ld_op_t ld_bu   = 5'b00100;
  localparam ld_op_t ld_h    = 5'b00010;
  localparam ld_op_t ld_hu   = 5'b00001;

  // EX to MEM payload
  typedef struct packed {
    logic [data_w-1:0] pc;
    // alu result, or the load address for loads
    logic [data_w-1:0] ex_result;
    logic              mul;
    logic [data_w-1:0] mul_result;
    ld_op_t            ld_op;
    logic              res_from_mem;
    logic              wait_data_ok;
    logic              rf_we;
    logic [rf_aw-1:0]  rf_waddr;
    logic              ertn;
    logic [ebus_w-1:0] ebus;
  } ex2mem_t;

  // MEM to WB payload
  typedef struct packed {
    logic [data_w-1:0] pc;
    logic [data_w-1:0] final_result;
    logic              rf_we;
    logic [rf_aw-1:0]  rf_waddr;
    logic              ertn;
    logic [ebus_w-1:0] ebus;
  } mem2wb_t;

endpackage

// ==== pipe_reg.sv ====
module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     load,
  input  payload_t d,
  output payload_t q
);

  // stage payload captured when the upstream stage hands over
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      q <= '0;
    end else if (load) begin
      q <= d;
    end
  end

endmodule

// ==== load_align.sv ====
module load_align (
  input  logic [1:0]                  addr_lo,
  input  logic [pipe_pkg::data_w-1:0] rdata,
  input  pipe_pkg::ld_op_t            ld_op,
  output logic [pipe_pkg::data_w-1:0] load_data
);
  import pipe_pkg::*;

  logic              is_signed;
  logic [7:0]        byte_sel;
  logic [15:0]       half_sel;
  logic [data_w-1:0] byte_ext;
  logic [data_w-1:0] half_ext;

  // bu and hu zero-fill while the others extend the sign
  assign is_signed = ~|(ld_op & (ld_bu | ld_hu));

  // byte lane by both address bits
  always_comb begin
    case (addr_lo)
      2'd0:    byte_sel = rdata[7:0];
      2'd1:    byte_sel = rdata[15:8];
      2'd2:    byte_sel = rdata[23:16];
      default: byte_sel = rdata[31:24];
    endcase
  end

  // halfword by address bit 1 only
  assign half_sel = addr_lo[1] ? rdata[31:16] : rdata[15:0];

  assign byte_ext = {{(data_w - 8){byte_sel[7] & is_signed}}, byte_sel};
  assign half_ext = {{(data_w - 16){half_sel[15] & is_signed}}, half_sel};

  always_comb begin
    load_data = '0;
    if (|(ld_op & ld_w)) begin
      load_data = rdata;
    end else if (|(ld_op & (ld_b | ld_bu))) begin
      load_data = byte_ext;
    end else if (|(ld_op & (ld_h | ld_hu))) begin
      load_data = half_ext;
    end
  end

endmodule

// ==== mem_stage.sv ====
module mem_stage (
  input  logic                        mem_valid,
  input  pipe_pkg::ex2mem_t           mem_in,
  input  logic                        data_sram_data_ok,
  input  logic [pipe_pkg::data_w-1:0] data_sram_rdata,
  output logic                        mem_ready_go,
  output logic                        mem_fwd_we,
  output logic [pipe_pkg::rf_aw-1:0]  mem_fwd_waddr,
  output logic [pipe_pkg::data_w-1:0] mem_fwd_data,
  output pipe_pkg::mem2wb_t           mem_out
);
  import pipe_pkg::*;

  logic [data_w-1:0] load_data;
  logic [data_w-1:0] final_result;

  // low address bits come from the load address in ex_result
  load_align u_load_align (
    .addr_lo   (mem_in.ex_result[1:0]),
    .rdata     (data_sram_rdata),
    .ld_op     (mem_in.ld_op),
    .load_data (load_data)
  );

  // multiply wins over load data, load data over the alu result
  always_comb begin
    if (mem_in.mul) begin
      final_result = mem_in.mul_result;
    end else if (mem_in.res_from_mem) begin
      final_result = load_data;
    end else begin
      final_result = mem_in.ex_result;
    end
  end

  // a load holds the stage until the sram answers
  assign mem_ready_go = (mem_valid && mem_in.wait_data_ok) ? data_sram_data_ok : 1'b1;

  // bypass to the decode stage
  // data of a waiting load is only good in its data_ok cycle
  assign mem_fwd_we    = mem_valid & mem_in.rf_we;
  assign mem_fwd_waddr = mem_in.rf_waddr;
  assign mem_fwd_data  = final_result;

  // payload for WB
  always_comb begin
    mem_out.pc           = mem_in.pc;
    mem_out.final_result = final_result;
    mem_out.rf_we        = mem_in.rf_we;
    mem_out.rf_waddr     = mem_in.rf_waddr;
    mem_out.ertn         = mem_in.ertn;
    // MEM raises no exceptions so the bus passes through
    mem_out.ebus         = mem_in.ebus;
  end

endmodule

// ==== wb_stage.sv ====
module wb_stage (
  input  logic                        wb_valid,
  input  pipe_pkg::mem2wb_t           wb_in,
  output logic                        wb_commit,
  output logic [pipe_pkg::data_w-1:0] wb_pc,
  output logic                        wb_rf_we,
  output logic [pipe_pkg::rf_aw-1:0]  wb_rf_waddr,
  output logic [pipe_pkg::data_w-1:0] wb_rf_wdata,
  output logic                        wb_exc,
  output logic [pipe_pkg::ebus_w-1:0] wb_ebus,
  output logic                        ertn_flush
);

  logic has_exc;

  // any raised bit on the bus counts as an exception
  assign has_exc = |wb_in.ebus;

  assign wb_commit = wb_valid;
  assign wb_pc     = wb_in.pc;

  // excepting instructions and ertn never write the register file
  assign wb_rf_we    = wb_valid & wb_in.rf_we & ~has_exc & ~wb_in.ertn;
  assign wb_rf_waddr = wb_in.rf_waddr;
  assign wb_rf_wdata = wb_in.final_result;

  // exception report
  assign wb_exc  = wb_valid & has_exc;
  assign wb_ebus = wb_in.ebus;

  // exception return flushes younger instructions
  assign ertn_flush = wb_valid & wb_in.ertn & ~has_exc;

endmodule

// ==== pipe_ctrl.sv ====
module pipe_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic ex_valid,
  input  logic ex_ready_go,
  input  logic mem_ready_go,
  input  logic ertn_flush,
  output logic mem_allow_in,
  output logic ex_mem_load,
  output logic mem_wb_load,
  output logic mem_valid,
  output logic wb_valid
);

  logic wb_allow_in;
  logic ex_to_mem;
  logic mem_to_wb;

  // WB retires in one cycle and never stalls
  assign wb_allow_in = 1'b1;

  // MEM takes a new one when empty or when its current one moves on,
  // but never while a flush is under way
  assign mem_allow_in = ~ertn_flush & (~mem_valid | (mem_ready_go & wb_allow_in));

  assign ex_to_mem = ex_valid & ex_ready_go & mem_allow_in;

  // the MEM instruction is killed, not passed on, during a flush
  assign mem_to_wb = mem_valid & mem_ready_go & wb_allow_in & ~ertn_flush;

  assign ex_mem_load = ex_to_mem;
  assign mem_wb_load = mem_to_wb;

  // MEM valid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_valid <= 1'b0;
    end else if (ertn_flush) begin
      mem_valid <= 1'b0;
    end else if (mem_allow_in) begin
      mem_valid <= ex_valid & ex_ready_go;
    end
  end

  // WB valid
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid <= 1'b0;
    end else if (wb_allow_in) begin
      wb_valid <= mem_to_wb;
    end
  end

endmodule

// ==== mem_wb_top.sv ====
module mem_wb_top (
  input  logic                        clk,
  input  logic                        rst_n,

  // strobes and instruction fields from EX
  input  logic                        ex_valid,
  input  logic                        ex_ready_go,
  input  logic [pipe_pkg::data_w-1:0] ex_pc,
  input  logic [pipe_pkg::data_w-1:0] ex_result,
  input  logic                        ex_mul,
  input  logic [pipe_pkg::data_w-1:0] ex_mul_result,
  input  pipe_pkg::ld_op_t            ex_ld_op,
  input  logic                        ex_res_from_mem,
  input  logic                        ex_wait_data_ok,
  input  logic                        ex_rf_we,
  input  logic [pipe_pkg::rf_aw-1:0]  ex_rf_waddr,
  input  logic                        ex_ertn,
  input  logic [pipe_pkg::ebus_w-1:0] ex_ebus,

  // data sram response
  input  logic                        data_sram_data_ok,
  input  logic [pipe_pkg::data_w-1:0] data_sram_rdata,

  output logic                        mem_allow_in,

  // bypass
  output logic                        mem_fwd_we,
  output logic [pipe_pkg::rf_aw-1:0]  mem_fwd_waddr,
  output logic [pipe_pkg::data_w-1:0] mem_fwd_data,

  // commit
  output logic                        wb_commit,
  output logic [pipe_pkg::data_w-1:0] wb_pc,
  output logic                        wb_rf_we,
  output logic [pipe_pkg::rf_aw-1:0]  wb_rf_waddr,
  output logic [pipe_pkg::data_w-1:0] wb_rf_wdata,

  // exceptions
  output logic                        wb_exc,
  output logic [pipe_pkg::ebus_w-1:0] wb_ebus,
  output logic                        ertn_flush
);
  import pipe_pkg::*;

  ex2mem_t ex_in;
  ex2mem_t mem_in;
  mem2wb_t mem_out;
  mem2wb_t wb_in;

  logic mem_ready_go;
  logic ex_mem_load;
  logic mem_wb_load;
  logic mem_valid;
  logic wb_valid;

  // gather the loose EX fields into one payload
  assign ex_in = '{
    pc:           ex_pc,
    ex_result:    ex_result,
    mul:          ex_mul,
    mul_result:   ex_mul_result,
    ld_op:        ex_ld_op,
    res_from_mem: ex_res_from_mem,
    wait_data_ok: ex_wait_data_ok,
    rf_we:        ex_rf_we,
    rf_waddr:     ex_rf_waddr,
    ertn:         ex_ertn,
    ebus:         ex_ebus
  };

  pipe_ctrl u_pipe_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .ex_valid     (ex_valid),
    .ex_ready_go  (ex_ready_go),
    .mem_ready_go (mem_ready_go),
    .ertn_flush   (ertn_flush),
    .mem_allow_in (mem_allow_in),
    .ex_mem_load  (ex_mem_load),
    .mem_wb_load  (mem_wb_load),
    .mem_valid    (mem_valid),
    .wb_valid     (wb_valid)
  );

  pipe_reg #(.payload_t(ex2mem_t)) u_ex_mem_reg (
    .clk   (clk),
    .rst_n (rst_n),
    .load  (ex_mem_load),
    .d     (ex_in),
    .q     (mem_in)
  );

  mem_stage u_mem_stage (
    .mem_valid         (mem_valid),
    .mem_in            (mem_in),
    .data_sram_data_ok (data_sram_data_ok),
    .data_sram_rdata   (data_sram_rdata),
    .mem_ready_go      (mem_ready_go),
    .mem_fwd_we        (mem_fwd_we),
    .mem_fwd_waddr     (mem_fwd_waddr),
    .mem_fwd_data      (mem_fwd_data),
    .mem_out           (mem_out)
  );

  pipe_reg #(.payload_t(mem2wb_t)) u_mem_wb_reg (
    .clk   (clk),
    .rst_n (rst_n),
    .load  (mem_wb_load),
    .d     (mem_out),
    .q     (wb_in)
  );

  wb_stage u_wb_stage (
    .wb_valid    (wb_valid),
    .wb_in       (wb_in),
    .wb_commit   (wb_commit),
    .wb_pc       (wb_pc),
    .wb_rf_we    (wb_rf_we),
    .wb_rf_waddr (wb_rf_waddr),
    .wb_rf_wdata (wb_rf_wdata),
    .wb_exc      (wb_exc),
    .wb_ebus     (wb_ebus),
    .ertn_flush  (ertn_flush)
  );

endmodule

// ==== tb_mem_wb.sv ====
module tb_mem_wb;

  localparam int n_instr   = 400;
  localparam int max_cycle = n_instr * 8 + 100;

  logic        clk;
  logic        rst_n;
  logic        ex_valid;
  logic        ex_ready_go;
  logic [31:0] ex_pc;
  logic [31:0] ex_result;
  logic        ex_mul;
  logic [31:0] ex_mul_result;
  logic [4:0]  ex_ld_op;
  logic        ex_res_from_mem;
  logic        ex_wait_data_ok;
  logic        ex_rf_we;
  logic [4:0]  ex_rf_waddr;
  logic        ex_ertn;
  logic [15:0] ex_ebus;
  logic        data_sram_data_ok;
  logic [31:0] data_sram_rdata;
  logic        mem_allow_in;
  logic        mem_fwd_we;
  logic [4:0]  mem_fwd_waddr;
  logic [31:0] mem_fwd_data;
  logic        wb_commit;
  logic [31:0] wb_pc;
  logic        wb_rf_we;
  logic [4:0]  wb_rf_waddr;
  logic [31:0] wb_rf_wdata;
  logic        wb_exc;
  logic [15:0] wb_ebus;
  logic        ertn_flush;

  // instruction records indexed by issue order
  logic [31:0] r_pc     [0:n_instr-1];
  logic [31:0] r_res    [0:n_instr-1];
  logic        r_mul    [0:n_instr-1];
  logic [31:0] r_mulres [0:n_instr-1];
  logic [4:0]  r_ldop   [0:n_instr-1];
  logic        r_rfm    [0:n_instr-1];
  logic        r_wait   [0:n_instr-1];
  logic        r_we     [0:n_instr-1];
  logic [4:0]  r_waddr  [0:n_instr-1];
  logic        r_ertn   [0:n_instr-1];
  logic [15:0] r_ebus   [0:n_instr-1];
  logic [31:0] r_rdata  [0:n_instr-1];

  int          exp_q[$];
  int          errors;
  int          issued;
  int          accepted;
  int          cur_id;
  bit          holding;
  bit          flush_pending;
  bit          mem_full;
  int          mem_id;
  bit          resp_active;
  int          resp_id;
  int          resp_cnt;
  logic [31:0] seed;

  mem_wb_top dut (
    .clk               (clk),
    .rst_n             (rst_n),
    .ex_valid          (ex_valid),
    .ex_ready_go       (ex_ready_go),
    .ex_pc             (ex_pc),
    .ex_result         (ex_result),
    .ex_mul            (ex_mul),
    .ex_mul_result     (ex_mul_result),
    .ex_ld_op          (ex_ld_op),
    .ex_res_from_mem   (ex_res_from_mem),
    .ex_wait_data_ok   (ex_wait_data_ok),
    .ex_rf_we          (ex_rf_we),
    .ex_rf_waddr       (ex_rf_waddr),
    .ex_ertn           (ex_ertn),
    .ex_ebus           (ex_ebus),
    .data_sram_data_ok (data_sram_data_ok),
    .data_sram_rdata   (data_sram_rdata),
    .mem_allow_in      (mem_allow_in),
    .mem_fwd_we        (mem_fwd_we),
    .mem_fwd_waddr     (mem_fwd_waddr),
    .mem_fwd_data      (mem_fwd_data),
    .wb_commit         (wb_commit),
    .wb_pc             (wb_pc),
    .wb_rf_we          (wb_rf_we),
    .wb_rf_waddr       (wb_rf_waddr),
    .wb_rf_wdata       (wb_rf_wdata),
    .wb_exc            (wb_exc),
    .wb_ebus           (wb_ebus),
    .ertn_flush        (ertn_flush)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    r = next_rand();
    return int'(r[31:16]) % n;
  endfunction

  // expected final result of one record
  function automatic logic [31:0] ref_result(input int id);
    logic [31:0] sh;
    logic [1:0]  off;
    off = r_res[id][1:0];
    if (r_mul[id]) begin
      return r_mulres[id];
    end
    if (!r_rfm[id]) begin
      return r_res[id];
    end
    case (r_ldop[id])
      5'b10000: return r_rdata[id];
      5'b01000: begin
        sh = r_rdata[id] >> (8 * off);
        return {{24{sh[7]}}, sh[7:0]};
      end
      5'b00100: begin
        sh = r_rdata[id] >> (8 * off);
        return {24'h0, sh[7:0]};
      end
      5'b00010: begin
        sh = r_rdata[id] >> (16 * off[1]);
        return {{16{sh[15]}}, sh[15:0]};
      end
      5'b00001: begin
        sh = r_rdata[id] >> (16 * off[1]);
        return {16'h0, sh[15:0]};
      end
      default: return 32'h0;
    endcase
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic make_instr(input int id);
    int kind;
    int lk;
    kind        = rand_below(16);
    r_pc[id]    = 32'h1c00_0000 + id * 4;
    r_res[id]   = next_rand();
    r_mul[id]   = 1'b0;
    r_mulres[id] = next_rand();
    r_ldop[id]  = 5'b0;
    r_rfm[id]   = 1'b0;
    r_wait[id]  = 1'b0;
    r_we[id]    = rand_below(4) != 0;
    r_waddr[id] = rand_below(32);
    r_ertn[id]  = 1'b0;
    r_ebus[id]  = 16'h0;
    r_rdata[id] = 32'h0;
    lk          = rand_below(5);
    // first twenty cover every load kind at every offset
    if (id < 20) begin
      kind = 0;
      lk = id % 5;
      r_res[id][1:0] = id / 5;
    end
    if (kind <= 5 || kind == 7) begin
      r_ldop[id] = 5'b10000 >> lk;
      r_rfm[id]  = 1'b1;
      r_wait[id] = 1'b1;
    end
    if (kind == 6 || kind == 7) begin
      r_mul[id] = 1'b1;
    end
    if (kind == 14) begin
      r_ertn[id] = 1'b1;
    end
    if (kind == 15) begin
      r_ebus[id] = 16'h1 << rand_below(3);
    end
  endtask

  task automatic drive_step();
    if (!holding) begin
      if (issued < n_instr && rand_below(8) != 0) begin
        cur_id = issued;
        issued++;
        make_instr(cur_id);
        ex_pc           = r_pc[cur_id];
        ex_result       = r_res[cur_id];
        ex_mul          = r_mul[cur_id];
        ex_mul_result   = r_mulres[cur_id];
        ex_ld_op        = r_ldop[cur_id];
        ex_res_from_mem = r_rfm[cur_id];
        ex_wait_data_ok = r_wait[cur_id];
        ex_rf_we        = r_we[cur_id];
        ex_rf_waddr     = r_waddr[cur_id];
        ex_ertn         = r_ertn[cur_id];
        ex_ebus         = r_ebus[cur_id];
        holding         = 1'b1;
      end
    end
    ex_valid    = holding;
    ex_ready_go = rand_below(4) != 0;
  endtask

  // sram model that answers the load in MEM after its delay
  task automatic respond_step();
    data_sram_data_ok = 1'b0;
    data_sram_rdata   = next_rand();
    if (resp_active) begin
      if (resp_cnt == 0) begin
        data_sram_data_ok = 1'b1;
        r_rdata[resp_id]  = data_sram_rdata;
        resp_active       = 1'b0;
      end else begin
        resp_cnt--;
      end
    end
  endtask

  // MEM occupancy model, bypass check and accept bookkeeping
  task automatic edge_step();
    bit flush;
    bit dok;
    bit ready;
    flush = ertn_flush;
    dok   = data_sram_data_ok;
    ready = !mem_full || !r_wait[mem_id] || dok;
    check_val("mem_allow_in", mem_allow_in, !flush && ready);
    check_val("mem_fwd_we", mem_fwd_we, mem_full && r_we[mem_id]);
    if (mem_full && r_we[mem_id]) begin
      check_val("mem_fwd_waddr", mem_fwd_waddr, r_waddr[mem_id]);
      if (!r_wait[mem_id] || dok) begin
        check_val("mem_fwd_data", mem_fwd_data, ref_result(mem_id));
      end
    end
    if (mem_full && (flush || ready)) begin
      mem_full = 1'b0;
    end
    if (flush) begin
      flush_pending = 1'b0;
    end
    if (ex_valid && ex_ready_go && mem_allow_in) begin
      mem_full = 1'b1;
      mem_id   = cur_id;
      holding  = 1'b0;
      accepted++;
      if (!flush_pending) begin
        exp_q.push_back(cur_id);
        if (r_wait[cur_id]) begin
          resp_active = 1'b1;
          resp_id     = cur_id;
          resp_cnt    = rand_below(5);
        end
      end
      if (r_ertn[cur_id] && r_ebus[cur_id] == 16'h0) begin
        flush_pending = 1'b1;
      end
    end
  endtask

  // scoreboard for the commit port
  initial begin
    int id;
    bit exc;
    wait (rst_n === 1'b1);
    forever begin
      @(posedge clk);
      if (wb_commit) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("commit of pc %h with no instruction expected at %0t", wb_pc, $time);
        end else begin
          id  = exp_q.pop_front();
          exc = r_ebus[id] != 16'h0;
          check_val("wb_pc", wb_pc, r_pc[id]);
          check_val("wb_rf_we", wb_rf_we, r_we[id] && !exc && !r_ertn[id]);
          check_val("wb_rf_waddr", wb_rf_waddr, r_waddr[id]);
          check_val("wb_rf_wdata", wb_rf_wdata, ref_result(id));
          check_val("wb_exc", wb_exc, exc);
          check_val("wb_ebus", wb_ebus, r_ebus[id]);
          check_val("ertn_flush", ertn_flush, r_ertn[id] && !exc);
        end
      end else begin
        check_val("wb_rf_we", wb_rf_we, 1'b0);
        check_val("wb_exc", wb_exc, 1'b0);
        check_val("ertn_flush", ertn_flush, 1'b0);
      end
    end
  end

  initial begin
    int cycle;
    cycle = 0;
    while (cycle < max_cycle) begin
      @(posedge clk);
      cycle++;
    end
    $display("timeout after %0d cycles with %0d instructions accepted and %0d not committed",
             cycle, accepted, exp_q.size());
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    seed              = 32'h71e6;
    errors            = 0;
    issued            = 0;
    accepted          = 0;
    cur_id            = 0;
    holding           = 1'b0;
    flush_pending     = 1'b0;
    mem_full          = 1'b0;
    mem_id            = 0;
    resp_active       = 1'b0;
    resp_id           = 0;
    resp_cnt          = 0;
    rst_n             = 1'b0;
    ex_valid          = 1'b0;
    ex_ready_go       = 1'b0;
    ex_pc             = '0;
    ex_result         = '0;
    ex_mul            = 1'b0;
    ex_mul_result     = '0;
    ex_ld_op          = '0;
    ex_res_from_mem   = 1'b0;
    ex_wait_data_ok   = 1'b0;
    ex_rf_we          = 1'b0;
    ex_rf_waddr       = '0;
    ex_ertn           = 1'b0;
    ex_ebus           = '0;
    data_sram_data_ok = 1'b0;
    data_sram_rdata   = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    while (accepted < n_instr) begin
      @(negedge clk);
      respond_step();
      drive_step();
      @(posedge clk);
      edge_step();
    end
    // run until every expected commit has shown up
    while (exp_q.size() != 0) begin
      @(negedge clk);
      respond_step();
      drive_step();
      @(posedge clk);
      edge_step();
    end
    // a few quiet cycles to catch stray commits
    repeat (4) begin
      @(negedge clk);
      respond_step();
      drive_step();
      @(posedge clk);
      edge_step();
    end
    @(negedge clk);
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// ==== src.f ====
pipe_pkg.sv
pipe_reg.sv
load_align.sv
mem_stage.sv
wb_stage.sv
pipe_ctrl.sv
mem_wb_top.sv
tb_mem_wb.sv
